//--- common/dma_pkg.sv
////////////////////////////////////////
// shared constants for the host-write DMA engine
// widths, TLP payload limits, control-word bits
// sequencer and interrupt state encodings
////////////////////////////////////////
package dma_pkg;

    ////////////////////////////////////////
    // widths
    localparam int DATA_W     = 64;           // sample and TX quadword
    localparam int SIZE_W     = 21;           // dma_size in bytes, up to 1 MB
    localparam int ADDR_W     = 32;           // host address
    localparam int PAYLOAD_W  = 8;            // payload size field, in DW
    localparam int TLP_CNT_W  = 15;           // full TLPs per request
    localparam int FIFO_CNT_W = 7;            // level count, 0..64
    localparam int TX_BUF_W   = 6;            // tx_buf_av from the PCIe core
    localparam int BUF_CNT_W  = 3;            // completed-buffer counter

    ////////////////////////////////////////
    // payload and thresholds
    localparam logic [PAYLOAD_W-1:0]  MAX_PAYLOAD_DW  = 8'd32;  // check lspci MaxPayload
    localparam logic [ADDR_W-1:0]     MAX_PAYLOAD_B   = 32'd128; // host address step
    localparam logic [FIFO_CNT_W-1:0] FIFO_DEPTH      = 7'd64;  // quadwords
    localparam logic [FIFO_CNT_W-1:0] PROG_FULL_LEVEL = 7'd56;  // data_ready falls here
    localparam logic [TX_BUF_W-1:0]   TX_BUF_MIN      = 6'd1;   // need more than this
    localparam int IRQ_DELAY = 3;             // req end -> irq decision

    // control_reg bit positions
    localparam int DMAE_BIT    = 0;           // dma enable
    localparam int DMAIE_BIT   = 1;           // msi enable
    localparam int DMA_RST_BIT = 2;           // sample fifo clear

    typedef enum logic [2:0] {
        IDLE,
        FIRST_TLP,                            // load base address
        NEXT_TLP,                             // step address
        WAIT_ACK,
        WAIT_ACK_LOW,
        REQ_END
    } seq_state_e;

    typedef enum logic [0:0] {
        IRQ_IDLE,
        IRQ_WAIT_RDY
    } irq_state_e;

endpackage

//--- hw/dma_ctrl_regs.sv
////////////////////////////////////////
// control word decode and enable edge detect
// TLP split of the request size
// completed-buffer count and status word
////////////////////////////////////////
`timescale 1ns/1ps

module dma_ctrl_regs (
    input  logic                          pcie_user_clk,
    input  logic                          pcie_user_rst_n,
    input  logic [31:0]                   control_reg_i,
    input  logic [dma_pkg::SIZE_W-1:0]    dma_size_i,      // bytes
    input  logic [dma_pkg::ADDR_W-1:0]    dma_ha_i,
    input  logic                          req_done_i,
    input  logic                          dma_compl_i,
    output logic                          dma_en_o,
    output logic                          dma_start_o,
    output logic                          dmaie_o,
    output logic                          fifo_clear_o,
    output logic [dma_pkg::TLP_CNT_W-1:0] num_full_tlps_o,
    output logic [dma_pkg::PAYLOAD_W-1:0] remainder_dw_o,
    output logic [7:0]                    dma_status_o
);

    logic [2:0]                    dmae_q;     // 2 sync stages + edge reg
    logic [dma_pkg::BUF_CNT_W-1:0] buf_cnt_q;
    logic [31:0]                   size_dw;
    logic [31:0]                   full_cnt;
    logic [31:0]                   rem_cnt;
    logic                          ha_not_zero;

    assign dma_en_o     = control_reg_i[dma_pkg::DMAE_BIT];
    assign dmaie_o      = control_reg_i[dma_pkg::DMAIE_BIT];
    assign fifo_clear_o = control_reg_i[dma_pkg::DMA_RST_BIT];
    assign ha_not_zero  = (dma_ha_i != '0);  // host must set the target first

    ////////////////////////////////////////
    // split, combinational
    // odd DW count rounds up to a full QW downstream
    assign size_dw  = 32'(dma_size_i[dma_pkg::SIZE_W-1:2]);
    assign full_cnt = size_dw / 32'(dma_pkg::MAX_PAYLOAD_DW);
    assign rem_cnt  = size_dw % 32'(dma_pkg::MAX_PAYLOAD_DW);
    assign num_full_tlps_o = full_cnt[dma_pkg::TLP_CNT_W-1:0];
    assign remainder_dw_o  = rem_cnt[dma_pkg::PAYLOAD_W-1:0]; // < MAX_PAYLOAD_DW

    // status: upper bits zero, completion flag, buffer count
    assign dma_status_o = 8'({dma_compl_i, buf_cnt_q});

    always_ff @(posedge pcie_user_clk) begin
        if (!pcie_user_rst_n) begin
            dmae_q      <= '0;
            dma_start_o <= 1'b0;
            buf_cnt_q   <= '0;
        end else begin
            dmae_q      <= {dmae_q[1:0], dma_en_o};
            // L->H on dmae, 3 cycles after control_reg shows it
            dma_start_o <= (dmae_q[2:1] == 2'b01) && ha_not_zero;
            if (req_done_i)
                buf_cnt_q <= buf_cnt_q + 1'b1;     // wraps, host tracks it
        end
    end

endmodule

//--- hw/tlp_sequencer/tlp_sequencer.sv
////////////////////////////////////////
// TLP request sequencer
// splits a DMA request into TLPs and runs the
// four-phase req/ack with the TX engine
////////////////////////////////////////
`timescale 1ns/1ps

module tlp_sequencer (
    input  logic                           pcie_user_clk,
    input  logic                           pcie_user_rst_n,
    input  logic                           dma_start_i,
    input  logic                           dma_en_i,
    input  logic [dma_pkg::ADDR_W-1:0]     dma_ha_i,
    input  logic [dma_pkg::TLP_CNT_W-1:0]  num_full_tlps_i,
    input  logic [dma_pkg::PAYLOAD_W-1:0]  remainder_dw_i,
    input  logic [dma_pkg::TX_BUF_W-1:0]   tx_buf_av_i,
    input  logic [dma_pkg::FIFO_CNT_W-1:0] fifo_level_i,
    input  logic                           dma_tlp_compl_done_i, // ack
    output logic                           tlp_req_o,
    output logic [dma_pkg::PAYLOAD_W-1:0]  dma_tlp_payload_size_o, // DW
    output logic [dma_pkg::ADDR_W-1:0]     host_addr_tx_o,
    output logic                           req_done_o
);

    dma_pkg::seq_state_e           state_q;
    logic [dma_pkg::TLP_CNT_W-1:0] tlps2go_q;   // full TLPs still to send
    logic [dma_pkg::PAYLOAD_W-1:0] rem_left_q;  // remainder DW, 0 once sent
    logic [dma_pkg::PAYLOAD_W-1:0] next_pl;
    logic                          tlp_ok;

    // full TLPs go first, the remainder last
    assign next_pl = (tlps2go_q != '0) ? dma_pkg::MAX_PAYLOAD_DW : rem_left_q;

    // tx credits and every QW of the next TLP already in the fifo
    assign tlp_ok = (tx_buf_av_i > dma_pkg::TX_BUF_MIN) &&
                    (32'(fifo_level_i) >= (32'(next_pl) + 32'd1) / 32'd2);

    assign req_done_o = (state_q == dma_pkg::REQ_END); // one cycle

    always_ff @(posedge pcie_user_clk) begin
        if (!pcie_user_rst_n) begin
            state_q                <= dma_pkg::IDLE;
            tlp_req_o              <= 1'b0;
            dma_tlp_payload_size_o <= '0;
            host_addr_tx_o         <= '0;
            tlps2go_q              <= '0;
            rem_left_q             <= '0;
        end else begin
            case (state_q)
                dma_pkg::IDLE: begin
                    tlp_req_o              <= 1'b0;
                    dma_tlp_payload_size_o <= '0;
                    if (dma_start_i) begin            // split is sampled here
                        tlps2go_q  <= num_full_tlps_i;
                        rem_left_q <= remainder_dw_i;
                        state_q    <= dma_pkg::FIRST_TLP;
                    end
                end

                dma_pkg::FIRST_TLP, dma_pkg::NEXT_TLP: begin
                    if (!dma_en_i) begin
                        state_q <= dma_pkg::IDLE;     // abort, no req_done
                    end else if (next_pl == '0) begin
                        state_q <= dma_pkg::REQ_END;  // nothing left
                    end else if (tlp_ok) begin
                        // base on the first TLP, one full payload further after
                        if (state_q == dma_pkg::FIRST_TLP)
                            host_addr_tx_o <= dma_ha_i;
                        else
                            host_addr_tx_o <= host_addr_tx_o + dma_pkg::MAX_PAYLOAD_B;
                        dma_tlp_payload_size_o <= next_pl;
                        tlp_req_o              <= 1'b1;
                        if (tlps2go_q != '0)
                            tlps2go_q <= tlps2go_q - 1'b1;
                        else
                            rem_left_q <= '0;         // remainder TLP is out
                        state_q <= dma_pkg::WAIT_ACK;
                    end
                end

                dma_pkg::WAIT_ACK: begin              // TX engine drains the fifo
                    if (dma_tlp_compl_done_i) begin
                        tlp_req_o <= 1'b0;            // drop the cycle after the ack
                        state_q   <= dma_pkg::WAIT_ACK_LOW;
                    end else if (!dma_en_i) begin
                        tlp_req_o <= 1'b0;
                        state_q   <= dma_pkg::IDLE;
                    end
                end

                dma_pkg::WAIT_ACK_LOW: begin
                    if (!dma_tlp_compl_done_i)        // phase 4 done
                        state_q <= dma_pkg::NEXT_TLP;
                end

                dma_pkg::REQ_END:
                    state_q <= dma_pkg::IDLE;

                default:
                    state_q <= dma_pkg::IDLE;
            endcase
        end
    end

endmodule

//--- hw/sample_fifo/sample_fifo.sv
////////////////////////////////////////
// synchronous FWFT sample fifo
// level count, prog-full ready flag
// byte swap to PCIe order on the read side
////////////////////////////////////////
`timescale 1ns/1ps

module sample_fifo (
    input  logic                           pcie_user_clk,
    input  logic                           pcie_user_rst_n,
    input  logic                           fifo_clear_i,
    input  logic [dma_pkg::DATA_W-1:0]     adc_data_i,
    input  logic                           adc_data_en_i,
    input  logic                           fifo_rd_en_i,
    output logic [dma_pkg::DATA_W-1:0]     dma_data_tx_o,  // valid with rd_en
    output logic [dma_pkg::FIFO_CNT_W-1:0] fifo_level_o,
    output logic                           data_ready_o
);

    logic [dma_pkg::DATA_W-1:0]              mem_q [dma_pkg::FIFO_DEPTH];
    logic [$clog2(dma_pkg::FIFO_DEPTH)-1:0]  wr_ptr_q;   // wraps at depth
    logic [$clog2(dma_pkg::FIFO_DEPTH)-1:0]  rd_ptr_q;
    logic [dma_pkg::FIFO_CNT_W-1:0]          level_q;
    logic [dma_pkg::DATA_W-1:0]              rd_word;
    logic                                    wr_ok;
    logic                                    rd_ok;

    assign wr_ok = adc_data_en_i && (level_q != dma_pkg::FIFO_DEPTH); // drop when full
    assign rd_ok = fifo_rd_en_i && (level_q != '0);                   // no underflow

    always_ff @(posedge pcie_user_clk) begin
        if (wr_ok)
            mem_q[wr_ptr_q] <= adc_data_i;
    end

    always_ff @(posedge pcie_user_clk) begin
        if (!pcie_user_rst_n || fifo_clear_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            level_q  <= '0;
        end else begin
            if (wr_ok)
                wr_ptr_q <= wr_ptr_q + 1'b1;
            if (rd_ok)
                rd_ptr_q <= rd_ptr_q + 1'b1;
            case ({wr_ok, rd_ok})
                2'b10:   level_q <= level_q + 1'b1;
                2'b01:   level_q <= level_q - 1'b1;
                default: level_q <= level_q;     // none, or both at once
            endcase
        end
    end

    assign rd_word      = mem_q[rd_ptr_q];         // head word, fwft
    assign fifo_level_o = level_q;
    assign data_ready_o = (level_q < dma_pkg::PROG_FULL_LEVEL);

    ////////////////////////////////////////
    // reverse bytes inside each 32-bit half
    always_comb begin
        for (int w = 0; w < dma_pkg::DATA_W / 32; w++) begin
            for (int b = 0; b < 4; b++) begin
                dma_data_tx_o[w*32 + b*8 +: 8] = rd_word[w*32 + (3-b)*8 +: 8];
            end
        end
    end

endmodule

//--- hw/dma_irq_ctrl.sv
////////////////////////////////////////
// end-of-request delay, MSI request
// and completion flag
////////////////////////////////////////
`timescale 1ns/1ps

module dma_irq_ctrl (
    input  logic pcie_user_clk,
    input  logic pcie_user_rst_n,
    input  logic req_done_i,
    input  logic dmaie_i,
    input  logic cfg_interrupt_rdy_i,
    input  logic dma_compl_acq_i,      // host has seen the buffer
    output logic cfg_interrupt_o,
    output logic dma_compl_o
);

    logic [dma_pkg::IRQ_DELAY-1:0] done_dly_q; // lets the last data leave first
    dma_pkg::irq_state_e           irq_state_q;

    always_ff @(posedge pcie_user_clk) begin
        if (!pcie_user_rst_n) begin
            done_dly_q      <= '0;
            irq_state_q     <= dma_pkg::IRQ_IDLE;
            cfg_interrupt_o <= 1'b0;
            dma_compl_o     <= 1'b0;
        end else begin
            done_dly_q <= {done_dly_q[dma_pkg::IRQ_DELAY-2:0], req_done_i};
            if (dma_compl_acq_i)
                dma_compl_o <= 1'b0;           // a new completion below wins
            case (irq_state_q)
                dma_pkg::IRQ_IDLE: begin
                    // decision point, irq only when DMAIE is set
                    if (dmaie_i && done_dly_q[dma_pkg::IRQ_DELAY-1]) begin
                        cfg_interrupt_o <= 1'b1;
                        dma_compl_o     <= 1'b1;
                        irq_state_q     <= dma_pkg::IRQ_WAIT_RDY;
                    end
                end
                dma_pkg::IRQ_WAIT_RDY: begin
                    if (cfg_interrupt_rdy_i) begin  // core took the MSI
                        cfg_interrupt_o <= 1'b0;
                        irq_state_q     <= dma_pkg::IRQ_IDLE;
                    end
                end
            endcase
        end
    end

endmodule

//--- hw/pci_dma_engine.sv
////////////////////////////////////////
// host-write DMA engine top
// control regs, TLP sequencer, sample fifo, irq
////////////////////////////////////////
`timescale 1ns/1ps

module pci_dma_engine (
    input  logic                          pcie_user_clk,
    input  logic                          pcie_user_rst_n,
    // register interface
    input  logic [31:0]                   control_reg_i,
    input  logic [dma_pkg::SIZE_W-1:0]    dma_size_i,
    input  logic [dma_pkg::ADDR_W-1:0]    dma_ha_i,
    input  logic                          dma_compl_acq_i,
    output logic [7:0]                    dma_status_o,
    // TX engine
    input  logic [dma_pkg::TX_BUF_W-1:0]  tx_buf_av_i,
    input  logic                          fifo_rd_en_i,
    input  logic                          dma_tlp_compl_done_i,
    output logic                          tlp_req_o,
    output logic [dma_pkg::PAYLOAD_W-1:0] dma_tlp_payload_size_o,
    output logic [dma_pkg::ADDR_W-1:0]    host_addr_tx_o,
    output logic [dma_pkg::DATA_W-1:0]    dma_data_tx_o,
    // MSI
    input  logic                          cfg_interrupt_rdy_i,
    output logic                          cfg_interrupt_o,
    // acquisition samples
    input  logic [dma_pkg::DATA_W-1:0]    adc_data_i,
    input  logic                          adc_data_en_i,
    output logic                          data_ready_o
);

    logic                           dma_start;
    logic                           dma_en;
    logic                           dmaie;
    logic                           fifo_clear;
    logic [dma_pkg::TLP_CNT_W-1:0]  num_full_tlps;
    logic [dma_pkg::PAYLOAD_W-1:0]  remainder_dw;
    logic                           req_done;
    logic                           dma_compl;
    logic [dma_pkg::FIFO_CNT_W-1:0] fifo_level;

    dma_ctrl_regs i_ctrl_regs (
        .pcie_user_clk   (pcie_user_clk),
        .pcie_user_rst_n (pcie_user_rst_n),
        .control_reg_i   (control_reg_i),
        .dma_size_i      (dma_size_i),
        .dma_ha_i        (dma_ha_i),
        .req_done_i      (req_done),
        .dma_compl_i     (dma_compl),
        .dma_en_o        (dma_en),
        .dma_start_o     (dma_start),
        .dmaie_o         (dmaie),
        .fifo_clear_o    (fifo_clear),
        .num_full_tlps_o (num_full_tlps),
        .remainder_dw_o  (remainder_dw),
        .dma_status_o    (dma_status_o)
    );

    tlp_sequencer i_tlp_sequencer (
        .pcie_user_clk          (pcie_user_clk),
        .pcie_user_rst_n        (pcie_user_rst_n),
        .dma_start_i            (dma_start),
        .dma_en_i               (dma_en),
        .dma_ha_i               (dma_ha_i),
        .num_full_tlps_i        (num_full_tlps),
        .remainder_dw_i         (remainder_dw),
        .tx_buf_av_i            (tx_buf_av_i),
        .fifo_level_i           (fifo_level),
        .dma_tlp_compl_done_i   (dma_tlp_compl_done_i),
        .tlp_req_o              (tlp_req_o),
        .dma_tlp_payload_size_o (dma_tlp_payload_size_o),
        .host_addr_tx_o         (host_addr_tx_o),
        .req_done_o             (req_done)
    );

    sample_fifo i_sample_fifo (
        .pcie_user_clk   (pcie_user_clk),
        .pcie_user_rst_n (pcie_user_rst_n),
        .fifo_clear_i    (fifo_clear),
        .adc_data_i      (adc_data_i),
        .adc_data_en_i   (adc_data_en_i),
        .fifo_rd_en_i    (fifo_rd_en_i),
        .dma_data_tx_o   (dma_data_tx_o),
        .fifo_level_o    (fifo_level),
        .data_ready_o    (data_ready_o)
    );

    dma_irq_ctrl i_irq_ctrl (
        .pcie_user_clk       (pcie_user_clk),
        .pcie_user_rst_n     (pcie_user_rst_n),
        .req_done_i          (req_done),
        .dmaie_i             (dmaie),
        .cfg_interrupt_rdy_i (cfg_interrupt_rdy_i),
        .dma_compl_acq_i     (dma_compl_acq_i),
        .cfg_interrupt_o     (cfg_interrupt_o),
        .dma_compl_o         (dma_compl)
    );

endmodule

//--- tests/pci_dma_engine_checker.sv
////////////////////////////////////////
// concurrent checks on the TX req/ack
// and the MSI handshake, bound into the top
////////////////////////////////////////
`timescale 1ns/1ps

module pci_dma_engine_checker (
    input logic                          pcie_user_clk,
    input logic                          pcie_user_rst_n,
    input logic                          tlp_req_i,
    input logic                          tlp_ack_i,
    input logic [dma_pkg::PAYLOAD_W-1:0] payload_dw_i,
    input logic [dma_pkg::ADDR_W-1:0]    host_addr_i,
    input logic                          cfg_interrupt_i,
    input logic                          cfg_interrupt_rdy_i
);

    int fail_cnt = 0;   // failures so far, polled by the testbench

    ////////////////////////////////////////
    // TX engine four-phase handshake
    req_held: assert property (@(posedge pcie_user_clk) disable iff (!pcie_user_rst_n)
        tlp_req_i && !tlp_ack_i |=> tlp_req_i)
        else begin fail_cnt++; $error("tlp_req_o fell before the ack"); end

    req_stable: assert property (@(posedge pcie_user_clk) disable iff (!pcie_user_rst_n)
        tlp_req_i && $past(tlp_req_i) |-> $stable(payload_dw_i) && $stable(host_addr_i))
        else begin fail_cnt++; $error("payload size or address moved under a request"); end

    req_drop: assert property (@(posedge pcie_user_clk) disable iff (!pcie_user_rst_n)
        tlp_req_i && tlp_ack_i |=> !tlp_req_i)   // one cycle after the ack
        else begin fail_cnt++; $error("tlp_req_o still high the cycle after the ack"); end

    req_no_overlap: assert property (@(posedge pcie_user_clk) disable iff (!pcie_user_rst_n)
        $rose(tlp_req_i) |-> !tlp_ack_i)         // ack must be low first
        else begin fail_cnt++; $error("new request rose while the ack was high"); end

    ////////////////////////////////////////
    // MSI request held until the core is ready
    irq_held: assert property (@(posedge pcie_user_clk) disable iff (!pcie_user_rst_n)
        cfg_interrupt_i && !cfg_interrupt_rdy_i |=> cfg_interrupt_i)
        else begin fail_cnt++; $error("cfg_interrupt_o fell before ready"); end

    irq_drop: assert property (@(posedge pcie_user_clk) disable iff (!pcie_user_rst_n)
        cfg_interrupt_i && cfg_interrupt_rdy_i |=> !cfg_interrupt_i)
        else begin fail_cnt++; $error("cfg_interrupt_o still high after ready"); end

endmodule

bind pci_dma_engine pci_dma_engine_checker i_checker (
    .pcie_user_clk       (pcie_user_clk),
    .pcie_user_rst_n     (pcie_user_rst_n),
    .tlp_req_i           (tlp_req_o),
    .tlp_ack_i           (dma_tlp_compl_done_i),
    .payload_dw_i        (dma_tlp_payload_size_o),
    .host_addr_i         (host_addr_tx_o),
    .cfg_interrupt_i     (cfg_interrupt_o),
    .cfg_interrupt_rdy_i (cfg_interrupt_rdy_i)
);

//--- tests/tb_pci_dma_engine.sv
////////////////////////////////////////
// testbench for the host-write DMA engine
// TX engine, MSI core and sample source models
// split, data, irq, stall and gating scenarios
////////////////////////////////////////
`timescale 1ns/1ps

module tb_pci_dma_engine;

    localparam int SCENARIO_CYCLES = 5000;                 // all scenarios, rounded up
    localparam int CYCLE_LIMIT     = 4 * SCENARIO_CYCLES;

    logic                           pcie_user_clk;
    logic                           pcie_user_rst_n;
    logic [31:0]                    control_reg;
    logic [dma_pkg::SIZE_W-1:0]     dma_size;
    logic [dma_pkg::ADDR_W-1:0]     dma_ha;
    logic                           dma_compl_acq;
    logic [7:0]                     dma_status;
    logic [dma_pkg::TX_BUF_W-1:0]   tx_buf_av;
    logic                           fifo_rd_en;
    logic                           tlp_ack;
    logic                           tlp_req;
    logic [dma_pkg::PAYLOAD_W-1:0]  payload_dw;
    logic [dma_pkg::ADDR_W-1:0]     host_addr;
    logic [dma_pkg::DATA_W-1:0]     data_tx;
    logic                           cfg_interrupt_rdy;
    logic                           cfg_interrupt;
    logic [dma_pkg::DATA_W-1:0]     adc_data;
    logic                           adc_data_en;
    logic                           data_ready;

    logic [dma_pkg::DATA_W-1:0]     sample_q[$];   // written, not yet read
    logic [dma_pkg::PAYLOAD_W-1:0]  exp_size_q[$]; // TLPs still expected
    logic [dma_pkg::ADDR_W-1:0]     exp_addr_q[$];
    logic                           src_on;
    int                             req_cycles = 0;
    int                             irq_cycles = 0;
    int                             cycle_cnt  = 0;

    pci_dma_engine i_dut (
        .pcie_user_clk          (pcie_user_clk),
        .pcie_user_rst_n        (pcie_user_rst_n),
        .control_reg_i          (control_reg),
        .dma_size_i             (dma_size),
        .dma_ha_i               (dma_ha),
        .dma_compl_acq_i        (dma_compl_acq),
        .dma_status_o           (dma_status),
        .tx_buf_av_i            (tx_buf_av),
        .fifo_rd_en_i           (fifo_rd_en),
        .dma_tlp_compl_done_i   (tlp_ack),
        .tlp_req_o              (tlp_req),
        .dma_tlp_payload_size_o (payload_dw),
        .host_addr_tx_o         (host_addr),
        .dma_data_tx_o          (data_tx),
        .cfg_interrupt_rdy_i    (cfg_interrupt_rdy),
        .cfg_interrupt_o        (cfg_interrupt),
        .adc_data_i             (adc_data),
        .adc_data_en_i          (adc_data_en),
        .data_ready_o           (data_ready)
    );

    ////////////////////////////////////////
    // helpers
    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // PCIe byte order, each 32-bit half reversed
    function automatic logic [63:0] pcie_order(input logic [63:0] d);
        return {d[39:32], d[47:40], d[55:48], d[63:56], d[7:0], d[15:8], d[23:16], d[31:24]};
    endfunction

    function automatic logic [7:0] status_word(input logic compl, input logic [2:0] cnt);
        return {4'd0, compl, cnt};
    endfunction

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1, "first error, run stopped");
    endtask

    task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
        assert (got === exp)
            else fail_now($sformatf("Mismatch at %0t: %s expected 0x%0h, got 0x%0h",
                                    $time, name, exp, got));
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge pcie_user_clk);
    endtask

    // full TLPs of 32 DW, 128 B apart, then the remainder
    task automatic expect_tlps(input int size_b, input logic [31:0] base);
        int dw;
        int step;
        dw   = size_b / 4;
        step = int'(dma_pkg::MAX_PAYLOAD_DW);
        for (int i = 0; i < dw / step; i++) begin
            exp_size_q.push_back(dma_pkg::MAX_PAYLOAD_DW);
            exp_addr_q.push_back(base + 32'(i * step * 4));
        end
        if (dw % step != 0) begin
            exp_size_q.push_back(8'(dw % step));
            exp_addr_q.push_back(base + 32'((dw / step) * step * 4));
        end
    endtask

    task automatic start_dma(input int size_b, input logic [31:0] ha, input logic ie);
        dma_size = 21'(size_b);
        dma_ha   = ha;
        control_reg[dma_pkg::DMAIE_BIT] = ie;
        control_reg[dma_pkg::DMAE_BIT]  = 1'b1;   // rising edge starts it
    endtask

    task automatic stop_dma();
        control_reg[dma_pkg::DMAE_BIT] = 1'b0;
        wait_cycles(6);                           // let the sync chain see the 0
    endtask

    // stalled request aborted by the enable, no irq and no new buffer
    task automatic stall_and_abort(input logic [31:0] base);
        int req_mark;
        int irq_mark;
        req_mark = req_cycles;
        irq_mark = irq_cycles;
        start_dma(600, base, 1'b1);
        wait_cycles(30);
        assert (req_cycles == req_mark) else fail_now("TLP request raised while stalled");
        stop_dma();
        assert (irq_cycles == irq_mark) else fail_now("interrupt raised after an abort");
        check_val("dma_status_o", 64'(dma_status), 64'(status_word(1'b0, 3'd2)));
    endtask

    ////////////////////////////////////////
    // clock, monitors, timeout
    initial begin
        pcie_user_clk = 1'b0;
        forever #4 pcie_user_clk = ~pcie_user_clk;
    end

    always @(posedge pcie_user_clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (tlp_req)
            req_cycles = req_cycles + 1;
        if (cfg_interrupt)
            irq_cycles = irq_cycles + 1;
        if (i_dut.i_checker.fail_cnt != 0)
            fail_now("a handshake assertion in the bound checker failed");
        if (cycle_cnt >= CYCLE_LIMIT)
            fail_now($sformatf("timeout, no end of test after %0d cycles", cycle_cnt));
    end

    ////////////////////////////////////////
    // models
    initial begin : sample_source
        logic [31:0] lcg_state;
        lcg_state   = 32'he1233229;
        adc_data    = '0;
        adc_data_en = 1'b0;
        forever begin
            @(negedge pcie_user_clk);
            if (src_on && data_ready) begin       // stop while prog-full
                lcg_state      = lcg_next(lcg_state);
                adc_data[63:32] = lcg_state;
                lcg_state      = lcg_next(lcg_state);
                adc_data[31:0] = lcg_state;
                adc_data_en    = 1'b1;
                sample_q.push_back(adc_data);
            end else begin
                adc_data_en = 1'b0;
            end
        end
    end

    initial begin : tx_engine
        int n_qw;
        fifo_rd_en = 1'b0;
        tlp_ack    = 1'b0;
        forever begin
            @(negedge pcie_user_clk);
            if (tlp_req && !tlp_ack) begin
                assert (exp_size_q.size() != 0) else fail_now("TLP request not expected");
                check_val("dma_tlp_payload_size_o", 64'(payload_dw), 64'(exp_size_q.pop_front()));
                check_val("host_addr_tx_o", 64'(host_addr), 64'(exp_addr_q.pop_front()));
                n_qw = (int'(payload_dw) + 1) / 2;   // odd DW rounds up
                for (int i = 0; i < n_qw; i++) begin
                    fifo_rd_en = 1'b1;               // data valid with rd_en
                    check_val("dma_data_tx_o", data_tx, pcie_order(sample_q.pop_front()));
                    @(negedge pcie_user_clk);
                end
                fifo_rd_en = 1'b0;
                tlp_ack    = 1'b1;
                while (tlp_req)
                    @(negedge pcie_user_clk);
                wait_cycles(2);                      // ack lingers after the request drops
                tlp_ack = 1'b0;                      // phase 4
            end
        end
    end

    initial begin : msi_core
        cfg_interrupt_rdy = 1'b0;
        forever begin
            @(negedge pcie_user_clk);
            if (cfg_interrupt) begin
                wait_cycles(2);                      // core busy for a while
                cfg_interrupt_rdy = 1'b1;
                @(negedge pcie_user_clk);
                cfg_interrupt_rdy = 1'b0;
            end
        end
    end

    ////////////////////////////////////////
    // scenarios
    initial begin : scenarios
        int req_mark;
        int irq_mark;
        pcie_user_rst_n = 1'b0;
        control_reg     = '0;
        dma_size        = '0;
        dma_ha          = '0;
        dma_compl_acq   = 1'b0;
        tx_buf_av       = 6'd8;
        src_on          = 1'b0;
        wait_cycles(4);
        pcie_user_rst_n = 1'b1;
        check_val("tlp_req_o", 64'(tlp_req), 64'd0);
        check_val("cfg_interrupt_o", 64'(cfg_interrupt), 64'd0);
        check_val("dma_tlp_payload_size_o", 64'(payload_dw), 64'd0);
        check_val("dma_status_o", 64'(dma_status), 64'd0);
        check_val("data_ready_o", 64'(data_ready), 64'd1);

        // fill up to prog-full, source keeps running from here on
        src_on = 1'b1;
        while (data_ready)
            @(negedge pcie_user_clk);
        check_val("samples held at data_ready_o low", 64'(sample_q.size()),
                  64'(dma_pkg::PROG_FULL_LEVEL));

        // host address zero, enable edge ignored
        req_mark = req_cycles;
        start_dma(600, 32'h0, 1'b1);
        wait_cycles(20);
        assert (req_cycles == req_mark) else fail_now("request raised with host address zero");
        stop_dma();

        // 600 B, 4 full + 22 DW, with MSI
        expect_tlps(600, 32'h1000);
        start_dma(600, 32'h1000, 1'b1);
        while (!cfg_interrupt)
            @(negedge pcie_user_clk);
        check_val("TLPs left", 64'(exp_size_q.size()), 64'd0);
        check_val("dma_status_o", 64'(dma_status), 64'(status_word(1'b1, 3'd1)));
        dma_compl_acq = 1'b1;
        @(negedge pcie_user_clk);
        dma_compl_acq = 1'b0;
        check_val("dma_status_o", 64'(dma_status), 64'(status_word(1'b0, 3'd1)));
        stop_dma();

        // 64 B in a single TLP, DMAIE clear
        irq_mark = irq_cycles;
        expect_tlps(64, 32'h2000);
        start_dma(64, 32'h2000, 1'b0);
        while (dma_status[2:0] != 3'd2)
            @(negedge pcie_user_clk);
        wait_cycles(dma_pkg::IRQ_DELAY + 4);
        assert (irq_cycles == irq_mark) else fail_now("interrupt raised with DMAIE clear");
        check_val("TLPs left", 64'(exp_size_q.size()), 64'd0);
        check_val("dma_status_o", 64'(dma_status), 64'(status_word(1'b0, 3'd2)));
        stop_dma();

        // no tx credits
        tx_buf_av = dma_pkg::TX_BUF_MIN;
        stall_and_abort(32'h3000);
        tx_buf_av = 6'd8;

        // fifo short, emptied by the clear bit
        src_on = 1'b0;
        wait_cycles(1);
        control_reg[dma_pkg::DMA_RST_BIT] = 1'b1;
        wait_cycles(2);
        control_reg[dma_pkg::DMA_RST_BIT] = 1'b0;
        sample_q.delete();
        stall_and_abort(32'h4000);

        if (i_dut.i_checker.fail_cnt != 0) begin
            fail_now("a handshake assertion in the bound checker failed");
        end else begin
            $display("TB PASSED");
            $finish;
        end
    end

endmodule

//--- src.f
common/dma_pkg.sv
hw/dma_ctrl_regs.sv
hw/tlp_sequencer/tlp_sequencer.sv
hw/sample_fifo/sample_fifo.sv
hw/dma_irq_ctrl.sv
hw/pci_dma_engine.sv
tests/pci_dma_engine_checker.sv
tests/tb_pci_dma_engine.sv

//--- Makefile
# Verilator build and run of the DMA engine testbench

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --assert --timing -sv --top-module tb_pci_dma_engine \
		-f src.f -Mdir obj_dir -o sim_tb
	./obj_dir/sim_tb +verilator+error+limit+100

clean:
	rm -rf obj_dir
